//--- design/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN        32
`define CPU_RESET_PC    32'h08000000
`define CPU_NREGS       16
`define CPU_PC_IDX      4'd15
`define CPU_LR_IDX      4'd14

// memory width codes, log2 of the byte count
`define MEM_WIDTH_BYTE  2'd0
`define MEM_WIDTH_WORD  2'd2

`define ST_INIT         2'd0
`define ST_FETCH        2'd1
`define ST_DECODE       2'd2
`define ST_EXEC         2'd3

// nzcv bit positions inside flags_t
`define FLAG_N          3
`define FLAG_Z          2
`define FLAG_C          1
`define FLAG_V          0

`endif

//--- design/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// data-processing view, bits 27:25 = 00I
	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  itype;
		logic [3:0]  opcode;
		logic        s;
		logic [3:0]  rn;
		logic [3:0]  rd;
		logic [11:0] operand;
	} dp_fmt_t;

	// load/store view, bits 27:25 = 010 for immediate offset
	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  itype;
		logic        p;
		logic        u;
		logic        b;
		logic        w;
		logic        l;
		logic [3:0]  rn;
		logic [3:0]  rd;
		logic [11:0] offset;
	} ls_fmt_t;

	typedef union packed {
		dp_fmt_t dp;
		ls_fmt_t ls;
	} instr_u;

	typedef enum logic [1:0] {
		CLS_DP,
		CLS_LS,
		CLS_BRANCH,
		CLS_UNDEF
	} instr_class_e;

	typedef struct packed {
		instr_class_e cls;
		logic [3:0]   cond;
		logic [3:0]   opcode;
		logic         s;
		logic [3:0]   rn;
		logic [3:0]   rd;
		logic [3:0]   rm;
		logic         use_imm;
		logic [3:0]   rot;
		logic [7:0]   imm8;
		logic [1:0]   shift_type;
		logic [4:0]   shift_amt;
		logic         p;
		logic         u;
		logic         w;
		logic         l;
		logic         b;
		logic         link;
		logic [23:0]  br_off;
	} decoded_t;

	typedef struct packed {
		logic                 pass;
		logic                 rd_we;
		logic [3:0]           rd_idx;
		logic [`CPU_XLEN-1:0] rd_val;
		logic                 wb_we;
		logic [3:0]           wb_idx;
		logic [`CPU_XLEN-1:0] wb_val;
		flags_t               flags;
		logic                 flags_we;
		logic [`CPU_XLEN-1:0] next_pc;
		logic [`CPU_XLEN-1:0] mem_addr;
		logic [`CPU_XLEN-1:0] mem_wdata;
		logic [1:0]           mem_width;
		logic                 mem_read;
		logic                 mem_write;
	} exec_result_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] wdata;
		logic [1:0]           width;
		logic                 read;
		logic                 write;
	} mem_req_t;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] rdata;
		logic                 ok;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- design/arm_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module arm_sequencer (
	input  wire                   clk,
	input  wire                   rstn,
	input  cpu_pkg::mem_rsp_t     mem_rsp,
	output cpu_pkg::mem_req_t     mem_req,
	input  cpu_pkg::exec_result_t exec_res,
	input  wire [`CPU_XLEN-1:0]   pc,
	output cpu_pkg::instr_u       instr,
	output logic                  commit,
	output logic                  init_pc
);

	logic [1:0] state, state_nx;
	logic       data_access;

	assign data_access = exec_res.mem_read || exec_res.mem_write;

	always_comb begin
		state_nx = state;
		mem_req = '0;
		mem_req.width = `MEM_WIDTH_WORD;
		commit = 1'b0;
		init_pc = 1'b0;
		case (state)
			`ST_INIT: begin
				init_pc = 1'b1;
				state_nx = `ST_FETCH;
			end
			`ST_FETCH: begin
				mem_req.addr = pc;
				mem_req.read = 1'b1;
				if (mem_rsp.ok)
					state_nx = `ST_DECODE;
			end
			`ST_DECODE: state_nx = `ST_EXEC; // operands settle through decode
			`ST_EXEC: begin
				if (data_access) begin
					mem_req.addr = exec_res.mem_addr;
					mem_req.wdata = exec_res.mem_wdata;
					mem_req.width = exec_res.mem_width;
					mem_req.read = exec_res.mem_read;
					mem_req.write = exec_res.mem_write;
					commit = mem_rsp.ok; // hold until the access lands
				end else begin
					commit = 1'b1;
				end
				if (commit)
					state_nx = `ST_FETCH;
			end
			default: state_nx = `ST_INIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			state <= `ST_INIT;
		else
			state <= state_nx;
	end

	// instruction latch
	always_ff @(posedge clk) begin
		if (state == `ST_FETCH && mem_rsp.ok)
			instr <= mem_rsp.rdata;
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
		(mem_req.read || mem_req.write) && !mem_rsp.ok |=> $stable(mem_req));

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(mem_req.read && mem_req.write));

endmodule

`default_nettype wire

//--- design/arm_decode.sv
`default_nettype none
`timescale 1ns/1ns

module arm_decode (
	input  cpu_pkg::instr_u   instr,
	output cpu_pkg::decoded_t dec
);

	always_comb begin
		dec.cond = instr.dp.cond;
		dec.opcode = instr.dp.opcode;
		dec.s = instr.dp.s;
		dec.rn = instr.dp.rn;
		dec.rd = instr.dp.rd;
		// addressing mode 1 operand fields
		dec.rm = instr.dp.operand[3:0];
		dec.use_imm = instr.dp.itype[0];
		dec.rot = instr.dp.operand[11:8];
		dec.imm8 = instr.dp.operand[7:0];
		dec.shift_type = instr.dp.operand[6:5];
		dec.shift_amt = instr.dp.operand[11:7];
		dec.p = instr.ls.p;
		dec.u = instr.ls.u;
		dec.w = instr.ls.w;
		dec.l = instr.ls.l;
		dec.b = instr.ls.b;
		dec.link = instr[24];
		dec.br_off = instr[23:0];

		if (instr.dp.itype[2:1] == 2'b00) begin
			if (!instr.dp.itype[0] && instr.dp.operand[4])
				dec.cls = cpu_pkg::CLS_UNDEF; // reg shift, mul, halfword
			else if (instr.dp.opcode[3:2] == 2'b10 && !instr.dp.s)
				dec.cls = cpu_pkg::CLS_UNDEF; // psr transfers, bx
			else
				dec.cls = cpu_pkg::CLS_DP;
		end else if (instr.ls.itype == 3'b010) begin
			dec.cls = cpu_pkg::CLS_LS; // 12-bit offset rides in rot and imm8
		end else if (instr.dp.itype == 3'b101) begin
			dec.cls = cpu_pkg::CLS_BRANCH;
		end else begin
			dec.cls = cpu_pkg::CLS_UNDEF;
		end
	end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module reg_file (
	input  wire                 clk,
	input  wire                 rstn,
	input  wire                 commit,
	input  wire                 init_pc,
	input  wire [3:0]           ra,
	input  wire [3:0]           rb,
	input  wire [3:0]           rc,
	output logic [`CPU_XLEN-1:0] a,
	output logic [`CPU_XLEN-1:0] b,
	output logic [`CPU_XLEN-1:0] c,
	output logic [`CPU_XLEN-1:0] pc,
	input  wire                 w1_en,
	input  wire [3:0]           w1_idx,
	input  wire [`CPU_XLEN-1:0] w1_data,
	input  wire                 w2_en,
	input  wire [3:0]           w2_idx,
	input  wire [`CPU_XLEN-1:0] w2_data,
	input  wire [`CPU_XLEN-1:0] next_pc
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
	logic [`CPU_XLEN-1:0] pc_rd;

	assign pc = regs[`CPU_PC_IDX];
	assign pc_rd = pc + 32'd8; // r15 reads two words ahead

	assign a = (ra == `CPU_PC_IDX) ? pc_rd : regs[ra];
	assign b = (rb == `CPU_PC_IDX) ? pc_rd : regs[rb];
	assign c = (rc == `CPU_PC_IDX) ? pc_rd : regs[rc];

	always_ff @(posedge clk) begin
		if (!rstn || init_pc) begin
			regs[`CPU_PC_IDX] <= `CPU_RESET_PC;
		end else if (commit) begin
			regs[`CPU_PC_IDX] <= next_pc;
			// later writes win, so a load beats base writeback
			if (w2_en)
				regs[w2_idx] <= w2_data;
			if (w1_en)
				regs[w1_idx] <= w1_data;
		end
	end

endmodule

`default_nettype wire

//--- design/barrel_shifter.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module barrel_shifter (
	input  wire [`CPU_XLEN-1:0]  value,
	input  wire [3:0]            rot_imm,
	input  wire [7:0]            imm8,
	input  wire                  use_imm,
	input  wire [1:0]            shift_type,
	input  wire [4:0]            shift_amt,
	input  wire                  carry_in,
	output logic [`CPU_XLEN-1:0] operand,
	output logic                 carry_out
);

	logic [4:0]  rot;
	logic [63:0] imm_dbl;
	logic [63:0] val_dbl;
	logic [5:0]  lsl_bit;

	assign rot = {rot_imm, 1'b0};
	assign imm_dbl = {2{24'h0, imm8}} >> rot;
	assign val_dbl = {2{value}} >> shift_amt; // rotate right helper
	assign lsl_bit = 6'd32 - {1'b0, shift_amt};

	always_comb begin
		if (use_imm) begin
			operand = imm_dbl[31:0];
			carry_out = (rot == 5'd0) ? carry_in : imm_dbl[31];
		end else if (shift_amt == 5'd0) begin
			case (shift_type)
				2'b00: begin operand = value; carry_out = carry_in; end
				2'b01: begin operand = '0; carry_out = value[31]; end // lsr #32
				2'b10: begin operand = {32{value[31]}}; carry_out = value[31]; end
				default: begin operand = {carry_in, value[31:1]}; carry_out = value[0]; end // rrx
			endcase
		end else begin
			carry_out = value[shift_amt - 5'd1];
			case (shift_type)
				2'b00: begin
					operand = value << shift_amt;
					carry_out = value[lsl_bit[4:0]];
				end
				2'b01: operand = value >> shift_amt;
				2'b10: operand = $signed(value) >>> shift_amt;
				default: operand = val_dbl[31:0];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/alu.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module alu (
	input  wire [3:0]            opcode,
	input  wire [`CPU_XLEN-1:0]  a,
	input  wire [`CPU_XLEN-1:0]  b,
	input  cpu_pkg::flags_t      flags_in,
	input  wire                  shifter_carry,
	output logic [`CPU_XLEN-1:0] result,
	output cpu_pkg::flags_t      flags_out,
	output logic                 writes_rd
);

	logic [`CPU_XLEN-1:0] x, y;
	logic                 cin;
	logic                 arith;
	logic [`CPU_XLEN:0]   sum;

	// subtraction runs as x + ~y + 1, so carry out is the ARM C
	always_comb begin
		arith = 1'b1;
		x = a;
		y = b;
		cin = 1'b0;
		case (opcode)
			4'h2, 4'hA: begin y = ~b; cin = 1'b1; end // sub, cmp
			4'h3: begin x = b; y = ~a; cin = 1'b1; end // rsb
			4'h4, 4'hB: cin = 1'b0; // add, cmn
			4'h5: cin = flags_in.c;
			4'h6: begin y = ~b; cin = flags_in.c; end
			4'h7: begin x = b; y = ~a; cin = flags_in.c; end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {{`CPU_XLEN{1'b0}}, cin};

	always_comb begin
		case (opcode)
			4'h0, 4'h8: result = a & b;
			4'h1, 4'h9: result = a ^ b;
			4'hC: result = a | b;
			4'hD: result = b;
			4'hE: result = a & ~b;
			4'hF: result = ~b;
			default: result = sum[`CPU_XLEN-1:0];
		endcase
	end

	always_comb begin
		flags_out.n = result[`CPU_XLEN-1];
		flags_out.z = (result == '0);
		flags_out.c = arith ? sum[`CPU_XLEN] : shifter_carry;
		flags_out.v = arith ? (x[31] == y[31]) && (sum[31] != x[31]) : flags_in.v;
	end

	assign writes_rd = (opcode[3:2] != 2'b10); // tst, teq, cmp, cmn only set flags

endmodule

`default_nettype wire

//--- design/arm_execute.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module arm_execute (
	input  cpu_pkg::decoded_t     dec,
	input  wire [`CPU_XLEN-1:0]   a,
	input  wire [`CPU_XLEN-1:0]   b,
	input  wire [`CPU_XLEN-1:0]   c,
	input  wire [`CPU_XLEN-1:0]   pc,
	input  cpu_pkg::flags_t       flags,
	output cpu_pkg::exec_result_t res
);

	logic [3:0]           f;
	logic                 cond_ok;
	logic [`CPU_XLEN-1:0] shift_op, alu_res;
	logic                 shift_c, alu_wr;
	cpu_pkg::flags_t      alu_flags;
	logic [`CPU_XLEN-1:0] ls_off, ls_addr_ofs, br_target, seq_pc;

	assign f = flags;

	always_comb begin
		case (dec.cond)
			4'h0: cond_ok = f[`FLAG_Z];
			4'h1: cond_ok = !f[`FLAG_Z];
			4'h2: cond_ok = f[`FLAG_C];
			4'h3: cond_ok = !f[`FLAG_C];
			4'h4: cond_ok = f[`FLAG_N];
			4'h5: cond_ok = !f[`FLAG_N];
			4'h6: cond_ok = f[`FLAG_V];
			4'h7: cond_ok = !f[`FLAG_V];
			4'h8: cond_ok = f[`FLAG_C] && !f[`FLAG_Z]; // hi
			4'h9: cond_ok = !f[`FLAG_C] || f[`FLAG_Z];
			4'hA: cond_ok = f[`FLAG_N] == f[`FLAG_V];
			4'hB: cond_ok = f[`FLAG_N] != f[`FLAG_V];
			4'hC: cond_ok = !f[`FLAG_Z] && (f[`FLAG_N] == f[`FLAG_V]);
			4'hD: cond_ok = f[`FLAG_Z] || (f[`FLAG_N] != f[`FLAG_V]);
			4'hE: cond_ok = 1'b1;
			default: cond_ok = 1'b0; // nv
		endcase
	end

	barrel_shifter u_shift (
		.value      (b),
		.rot_imm    (dec.rot),
		.imm8       (dec.imm8),
		.use_imm    (dec.use_imm),
		.shift_type (dec.shift_type),
		.shift_amt  (dec.shift_amt),
		.carry_in   (flags.c),
		.operand    (shift_op),
		.carry_out  (shift_c)
	);

	alu u_alu (
		.opcode        (dec.opcode),
		.a             (a),
		.b             (shift_op),
		.flags_in      (flags),
		.shifter_carry (shift_c),
		.result        (alu_res),
		.flags_out     (alu_flags),
		.writes_rd     (alu_wr)
	);

	assign seq_pc = pc + 32'd4;
	assign br_target = pc + 32'd8 + {{6{dec.br_off[23]}}, dec.br_off, 2'b00};
	assign ls_off = {20'h0, dec.rot, dec.imm8};
	assign ls_addr_ofs = dec.u ? a + ls_off : a - ls_off;

	always_comb begin
		res = '0;
		res.pass = cond_ok;
		res.next_pc = seq_pc;
		res.flags = alu_flags;
		res.mem_width = `MEM_WIDTH_WORD;
		res.rd_idx = dec.rd;
		res.wb_idx = dec.rn;
		res.wb_val = ls_addr_ofs;
		case (dec.cls)
			cpu_pkg::CLS_DP: begin
				res.rd_we = cond_ok && alu_wr;
				res.rd_val = alu_res;
				res.flags_we = cond_ok && dec.s;
			end
			cpu_pkg::CLS_BRANCH: begin
				if (cond_ok)
					res.next_pc = br_target;
				res.rd_we = cond_ok && dec.link;
				res.rd_idx = `CPU_LR_IDX;
				res.rd_val = seq_pc;
			end
			cpu_pkg::CLS_LS: begin
				res.mem_addr = dec.p ? ls_addr_ofs : a; // post-index uses the bare base
				res.mem_wdata = dec.b ? {4{c[7:0]}} : c;
				res.mem_width = dec.b ? `MEM_WIDTH_BYTE : `MEM_WIDTH_WORD;
				res.mem_read = cond_ok && dec.l;
				res.mem_write = cond_ok && !dec.l;
				res.rd_we = cond_ok && dec.l;
				res.wb_we = cond_ok && (!dec.p || dec.w);
			end
			default: ; // undefined, just step over it
		endcase
	end

endmodule

`default_nettype wire

//--- design/result_commit.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module result_commit (
	input  wire                   clk,
	input  wire                   rstn,
	input  wire                   commit,
	input  cpu_pkg::exec_result_t res,
	input  wire [`CPU_XLEN-1:0]   rdata,
	output cpu_pkg::flags_t       flags,
	output logic                  w1_en,
	output logic [3:0]            w1_idx,
	output logic [`CPU_XLEN-1:0]  w1_data,
	output logic                  w2_en,
	output logic [3:0]            w2_idx,
	output logic [`CPU_XLEN-1:0]  w2_data
);

	logic [7:0]           load_byte;
	logic [`CPU_XLEN-1:0] load_val;

	always_ff @(posedge clk) begin
		if (!rstn)
			flags <= '0;
		else if (commit && res.flags_we)
			flags <= res.flags;
	end

	// byte lane picked by the low address bits
	always_comb begin
		case (res.mem_addr[1:0])
			2'd0: load_byte = rdata[7:0];
			2'd1: load_byte = rdata[15:8];
			2'd2: load_byte = rdata[23:16];
			default: load_byte = rdata[31:24];
		endcase
	end

	assign load_val = (res.mem_width == `MEM_WIDTH_BYTE) ? {24'h0, load_byte} : rdata;

	assign w1_en = res.rd_we;
	assign w1_idx = res.rd_idx;
	assign w1_data = res.mem_read ? load_val : res.rd_val; // alu, link or load

	assign w2_en = res.wb_we; // base writeback
	assign w2_idx = res.wb_idx;
	assign w2_data = res.wb_val;

	a_no_write_on_fail: assert property (@(posedge clk) disable iff (!rstn)
		commit && !res.pass |-> !(w1_en || w2_en || res.flags_we));

endmodule

`default_nettype wire

//--- design/cpu_core.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module cpu_core (
	input  wire              clk,
	input  wire              rstn,
	output cpu_pkg::mem_req_t mem_req,
	input  cpu_pkg::mem_rsp_t mem_rsp
);

	cpu_pkg::instr_u       instr;
	cpu_pkg::decoded_t     dec;
	cpu_pkg::exec_result_t res;
	cpu_pkg::flags_t       flags;

	logic [`CPU_XLEN-1:0] a, b, c;
	logic [`CPU_XLEN-1:0] pc;
	logic                 commit;
	logic                 init_pc;

	// register write ports, port 2 is base writeback
	logic                 w1_en, w2_en;
	logic [3:0]           w1_idx, w2_idx;
	logic [`CPU_XLEN-1:0] w1_data, w2_data;

	arm_sequencer u_seq (
		.clk      (clk),
		.rstn     (rstn),
		.mem_rsp  (mem_rsp),
		.mem_req  (mem_req),
		.exec_res (res),
		.pc       (pc),
		.instr    (instr),
		.commit   (commit),
		.init_pc  (init_pc)
	);

	arm_decode u_dec (
		.instr (instr),
		.dec   (dec)
	);

	reg_file u_rf (
		.clk     (clk),
		.rstn    (rstn),
		.commit  (commit),
		.init_pc (init_pc),
		.ra      (dec.rn),
		.rb      (dec.rm),
		.rc      (dec.rd), // store data
		.a       (a),
		.b       (b),
		.c       (c),
		.pc      (pc),
		.w1_en   (w1_en),
		.w1_idx  (w1_idx),
		.w1_data (w1_data),
		.w2_en   (w2_en),
		.w2_idx  (w2_idx),
		.w2_data (w2_data),
		.next_pc (res.next_pc)
	);

	arm_execute u_ex (
		.dec   (dec),
		.a     (a),
		.b     (b),
		.c     (c),
		.pc    (pc),
		.flags (flags),
		.res   (res)
	);

	result_commit u_commit (
		.clk     (clk),
		.rstn    (rstn),
		.commit  (commit),
		.res     (res),
		.rdata   (mem_rsp.rdata),
		.flags   (flags),
		.w1_en   (w1_en),
		.w1_idx  (w1_idx),
		.w1_data (w1_data),
		.w2_en   (w2_en),
		.w2_idx  (w2_idx),
		.w2_data (w2_data)
	);

endmodule

`default_nettype wire

//--- tb/tb_memory.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module tb_memory (
	input  wire               clk,
	input  wire               rstn,
	input  cpu_pkg::mem_req_t req,
	output cpu_pkg::mem_rsp_t rsp
);

	logic [31:0] mem [1024];
	logic        busy;
	int          cnt;

	// background pattern, distinct for every address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		fill_word = addr ^ 32'h5a5a_5a5a ^ {addr[15:0], addr[31:16]};
	endfunction

	initial begin
		logic [31:0] prog [42];
		void'($urandom(32'h8e56));
		for (int i = 0; i < 1024; i++)
			mem[i] = fill_word(`CPU_RESET_PC + 32'(i * 4));
		prog = '{32'hE3A0A408, 32'hE28AAB01, 32'hE3A014FF, 32'hE3A02005,
			32'hE0813002, 32'hE2424007, 32'hE3815030, 32'hE1A06201,
			32'hE1A07621, 32'hE1A08441, 32'hE58A3000, 32'hE58A4004,
			32'hE58A5008, 32'hE58A600C, 32'hE58A7010, 32'hE58A8014,
			32'hE3520003, 32'hE1A09062, 32'hE58A9018, 32'hE3A00011,
			32'h03A00022, 32'hC3A0B033, 32'hB3A0B044, 32'hE58A001C,
			32'hE58AB020, 32'hEA000000, 32'hE3A00099, 32'hEB000000,
			32'hE3A00099, 32'hE58AE024, 32'hE58A0028, 32'hE59A1000,
			32'hE5DA2017, 32'hE58A102C, 32'hE58A2030, 32'hE5CA5035,
			32'hE28AC040, 32'hE48C2008, 32'hE58C3000, 32'hE59A4034,
			32'hE58A4038, 32'hEAFFFFFE};
		for (int i = 0; i < 42; i++)
			mem[i] = prog[i];
		rsp = '0;
		busy = 1'b0;
		cnt = 0;
	end

	always @(posedge clk) begin
		int wait_now;
		logic [9:0] idx;
		logic [1:0] lane;
		idx = req.addr[11:2];
		lane = req.addr[1:0];
		if (!rstn) begin
			rsp.ok <= 1'b0;
			busy <= 1'b0;
		end else if (rsp.ok) begin
			rsp.ok <= 1'b0; // access completes this edge
			busy <= 1'b0;
		end else if (req.read || req.write) begin
			wait_now = busy ? cnt : int'($urandom_range(3, 0));
			busy <= 1'b1;
			if (wait_now == 0) begin
				rsp.ok <= 1'b1;
				rsp.rdata <= mem[idx];
				if (req.write && req.width == `MEM_WIDTH_BYTE)
					mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
				else if (req.write)
					mem[idx] <= req.wdata;
			end else begin
				cnt <= wait_now - 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_cpu_core.sv
`default_nettype none
`timescale 1ns/1ns

`include "cpu_macros.svh"

module tb_cpu_core;

	logic              clk;
	logic              rstn;
	cpu_pkg::mem_req_t req;
	cpu_pkg::mem_rsp_t rsp;

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [1:0]  exp_width [$];
	string       exp_name [$];
	int          st_idx;
	int          errors;
	logic        first_seen;

	cpu_core u_dut (
		.clk     (clk),
		.rstn    (rstn),
		.mem_req (req),
		.mem_rsp (rsp)
	);

	tb_memory u_mem (.clk(clk), .rstn(rstn), .req(req), .rsp(rsp));

	always #20 clk = ~clk;

	function automatic logic [31:0] background_word(input logic [31:0] addr);
		background_word = addr ^ 32'h5a5a_5a5a ^ {addr[15:0], addr[31:16]};
	endfunction

	task automatic expect_store(input string name, input logic [31:0] ofs,
		input logic [31:0] data, input logic [1:0] width);
		exp_name.push_back(name);
		exp_addr.push_back(32'h0800_0400 + ofs);
		exp_data.push_back(data);
		exp_width.push_back(width);
	endtask

	task automatic log_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// idle through reset and the init cycle
	a_reset_idle: assert property (@(posedge clk) (!rstn || $past(!rstn)) |->
		!(req.read || req.write))
		else log_error("request issued during reset or init");
	a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
		(req.read || req.write) && !rsp.ok |=> $stable(req))
		else log_error("request changed while waiting for ok");
	a_rd_wr: assert property (@(posedge clk) !(req.read && req.write))
		else log_error("read and write high together");
	a_b_target: assert property (@(posedge clk) disable iff (!rstn)
		req.read && rsp.ok && req.addr == 32'h0800_0064 |->
		##3 (req.read && req.addr == 32'h0800_006C))
		else log_error($sformatf("Mismatch b_target fetch expected %h actual %h",
			32'h0800_006C, $sampled(req.addr)));
	a_bl_target: assert property (@(posedge clk) disable iff (!rstn)
		req.read && rsp.ok && req.addr == 32'h0800_006C |->
		##3 (req.read && req.addr == 32'h0800_0074))
		else log_error($sformatf("Mismatch bl_target fetch expected %h actual %h",
			32'h0800_0074, $sampled(req.addr)));

	always @(posedge clk) begin
		logic [1:0] ln;
		if (rstn && !first_seen && (req.read || req.write)) begin
			first_seen <= 1'b1;
			a_first: assert (req.read && req.addr == `CPU_RESET_PC)
				else log_error($sformatf(
					"Mismatch first_fetch expected read at %h actual %s at %h",
					`CPU_RESET_PC, req.read ? "read" : "write", req.addr));
		end
		if (rstn && req.write && rsp.ok) begin
			if (st_idx >= exp_addr.size()) begin
				log_error($sformatf("unexpected store to %h", req.addr));
			end else begin
				ln = req.addr[1:0];
				a_addr: assert (req.addr == exp_addr[st_idx])
					else log_error($sformatf("Mismatch %s addr expected %h actual %h",
						exp_name[st_idx], exp_addr[st_idx], req.addr));
				a_width: assert (req.width == exp_width[st_idx])
					else log_error($sformatf("Mismatch %s width expected %0d actual %0d",
						exp_name[st_idx], exp_width[st_idx], req.width));
				if (exp_width[st_idx] == `MEM_WIDTH_BYTE) begin
					a_byte: assert (req.wdata[8*ln +: 8] == exp_data[st_idx][7:0])
						else log_error($sformatf("Mismatch %s data expected %h actual %h",
							exp_name[st_idx], exp_data[st_idx][7:0],
							req.wdata[8*ln +: 8]));
				end else begin
					a_word: assert (req.wdata == exp_data[st_idx])
						else log_error($sformatf("Mismatch %s data expected %h actual %h",
							exp_name[st_idx], exp_data[st_idx], req.wdata));
				end
			end
			st_idx <= st_idx + 1;
		end
	end

	initial begin
		int cycles;
		clk = 1'b0;
		rstn = 1'b0;
		st_idx = 0;
		errors = 0;
		first_seen = 1'b0;
		expect_store("add_reg", 32'h00, 32'hFF00_0005, `MEM_WIDTH_WORD);
		expect_store("sub_imm", 32'h04, 32'hFFFF_FFFE, `MEM_WIDTH_WORD);
		expect_store("orr_imm", 32'h08, 32'hFF00_0030, `MEM_WIDTH_WORD);
		expect_store("mov_lsl", 32'h0C, 32'hF000_0000, `MEM_WIDTH_WORD);
		expect_store("mov_lsr", 32'h10, 32'h000F_F000, `MEM_WIDTH_WORD);
		expect_store("mov_asr", 32'h14, 32'hFFFF_0000, `MEM_WIDTH_WORD);
		expect_store("mov_rrx", 32'h18, 32'h8000_0002, `MEM_WIDTH_WORD);
		expect_store("cond_eq", 32'h1C, 32'h0000_0011, `MEM_WIDTH_WORD);
		expect_store("cond_gt", 32'h20, 32'h0000_0033, `MEM_WIDTH_WORD);
		expect_store("bl_link", 32'h24, 32'h0800_0070, `MEM_WIDTH_WORD);
		expect_store("b_skip", 32'h28, 32'h0000_0011, `MEM_WIDTH_WORD);
		expect_store("ldr", 32'h2C, 32'hFF00_0005, `MEM_WIDTH_WORD);
		expect_store("ldrb", 32'h30, 32'h0000_00FF, `MEM_WIDTH_WORD);
		expect_store("strb", 32'h35, 32'h0000_0030, `MEM_WIDTH_BYTE);
		expect_store("post_idx", 32'h40, 32'h0000_00FF, `MEM_WIDTH_WORD);
		expect_store("post_wb", 32'h48, 32'hFF00_0005, `MEM_WIDTH_WORD);
		expect_store("strb_lane", 32'h38,
			(background_word(32'h0800_0434) & 32'hFFFF_00FF) | 32'h0000_3000,
			`MEM_WIDTH_WORD);
		repeat (16) @(posedge clk);
		rstn <= 1'b1;
		cycles = 0;
		while (st_idx < exp_addr.size() && cycles < 4000) begin
			@(posedge clk);
			cycles++;
		end
		if (st_idx < exp_addr.size())
			log_error($sformatf("timeout waiting for stores, %0d of %0d seen",
				st_idx, exp_addr.size()));
		repeat (4) @(posedge clk);
		$display("errors: %0d, stores checked: %0d", errors, st_idx);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu_core.f
+incdir+design
design/cpu_pkg.sv
design/arm_sequencer.sv
design/arm_decode.sv
design/reg_file.sv
design/barrel_shifter.sv
design/alu.sv
design/arm_execute.sv
design/result_commit.sv
design/cpu_core.sv
tb/tb_memory.sv
tb/tb_cpu_core.sv

//--- Makefile
SRCS := $(wildcard design/*.sv design/*.svh tb/*.sv) cpu_core.f

obj_dir/Vtb_cpu_core: $(SRCS)
	verilator --binary --timing --assert -f cpu_core.f --top-module tb_cpu_core -Mdir obj_dir

.PHONY: run clean

run: obj_dir/Vtb_cpu_core
	@out="$$(./obj_dir/Vtb_cpu_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
